// File: compile.f
design/aud_pkg.sv
design/sample_ram.sv
design/aud_dsp.sv
design/aud_player.sv
design/aud_top.sv
test/tb_aud_top.sv

// File: design/aud_dsp.sv
module aud_dsp (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_start,
	input  logic                         i_stop,
	input  logic                         i_pause,
	input  aud_pkg::play_mode_t          i_mode,
	input  logic [aud_pkg::SPEED_W-1:0]  i_speed,
	input  logic [aud_pkg::ADDR_W:0]     i_record_len,
	output logic [aud_pkg::ADDR_W-1:0]   o_rd_addr,
	input  logic [aud_pkg::SAMPLE_W-1:0] i_rd_data,
	output logic                         o_play_req,
	output logic [aud_pkg::SAMPLE_W-1:0] o_play_data,
	input  logic                         i_sent_done,
	output logic                         o_finish
);

	import aud_pkg::*;

	// control state
	dsp_state_t          state_r, state_w;
	play_mode_t          mode_r, mode_w;
	logic [SPEED_W-1:0]  speed_r, speed_w;
	logic [ADDR_W:0]     len_r, len_w;
	logic [ADDR_W:0]     pos_r, pos_w;
	logic [SPEED_W-1:0]  sub_r, sub_w;
	logic                final_r, final_w;
	logic                phase_r, phase_w;
	logic                req_r, req_w;
	logic                finish_r, finish_w;
	logic                start_r;

	// payload
	logic signed [SAMPLE_W-1:0] a_r, a_w;
	logic signed [SAMPLE_W-1:0] b_r, b_w;
	logic signed [SAMPLE_W-1:0] data_r, data_w;

	logic                       start_edge;
	logic                       single;
	logic                       sub_last;
	logic signed [SAMPLE_W:0]   diff;
	logic signed [SAMPLE_W:0]   step;
	logic signed [SAMPLE_W-1:0] acc_next;

	assign start_edge = i_start && !start_r;

	// fast mode and the closing sample of slow play need one read only
	assign single   = (mode_r == MODE_FAST) || final_r;
	assign sub_last = (sub_r == speed_r - SPEED_W'(1));

	// second read goes to the neighbour of the current position
	assign o_rd_addr = (state_r == S_FETCH_B) ? pos_r[ADDR_W-1:0] + ADDR_W'(1)
	                                          : pos_r[ADDR_W-1:0];

	// interpolation step, truncated toward zero
	assign diff     = b_r - a_r;
	assign step     = diff / $signed({1'b0, speed_r});
	// stays between a and b, so 16 bits are enough
	assign acc_next = data_r + $signed(step[SAMPLE_W-1:0]);

	assign o_play_req  = req_r;
	assign o_play_data = data_r;
	assign o_finish    = finish_r;

	always_comb begin
		state_w  = state_r;
		mode_w   = mode_r;
		speed_w  = speed_r;
		len_w    = len_r;
		pos_w    = pos_r;
		sub_w    = sub_r;
		final_w  = final_r;
		phase_w  = phase_r;
		req_w    = req_r;
		finish_w = 1'b0;
		a_w      = a_r;
		b_w      = b_r;
		data_w   = data_r;

		case (state_r)
			S_IDLE: begin
				req_w = 1'b0;
				if (start_edge) begin
					mode_w  = i_mode;
					speed_w = (i_speed == '0) ? SPEED_W'(1) : i_speed;
					len_w   = i_record_len;
					pos_w   = '0;
					sub_w   = '0;
					phase_w = 1'b0;
					// a one-sample recording goes straight to the closing sample
					final_w = (i_record_len == (ADDR_W+1)'(1));
					if (i_record_len == '0) begin
						finish_w = 1'b1;
					end else begin
						state_w = S_FETCH_A;
					end
				end
			end

			S_FETCH_A: begin
				state_w = S_FETCH_B;
			end

			S_FETCH_B: begin
				if (single) begin
					data_w  = $signed(i_rd_data);
					req_w   = !i_pause;
					state_w = S_SEND;
				end else begin
					a_w     = $signed(i_rd_data);
					phase_w = 1'b0;
					state_w = S_CALC;
				end
			end

			S_CALC: begin
				if (!phase_r) begin
					b_w     = $signed(i_rd_data);
					phase_w = 1'b1;
				end else begin
					// first output of a pair is always the left sample
					if (sub_r == '0 || mode_r != MODE_SLOW_LINEAR) begin
						data_w = a_r;
					end else begin
						data_w = acc_next;
					end
					req_w   = !i_pause;
					state_w = S_SEND;
				end
			end

			S_SEND: begin
				if (!req_r) begin
					// held back by pause, data already valid
					req_w = !i_pause;
				end else if (i_sent_done) begin
					req_w = 1'b0;
					if (mode_r == MODE_FAST) begin
						if (pos_r + speed_r < len_r) begin
							pos_w   = pos_r + speed_r;
							state_w = S_FETCH_A;
						end else begin
							finish_w = 1'b1;
							state_w  = S_IDLE;
						end
					end else if (final_r) begin
						finish_w = 1'b1;
						state_w  = S_IDLE;
					end else if (!sub_last) begin
						// next output of the same pair, no new reads
						sub_w   = sub_r + SPEED_W'(1);
						phase_w = 1'b1;
						state_w = S_CALC;
					end else begin
						pos_w   = pos_r + (ADDR_W+1)'(1);
						sub_w   = '0;
						final_w = (pos_r + (ADDR_W+1)'(2) == len_r);
						state_w = S_FETCH_A;
					end
				end
			end

			default: begin
				req_w   = 1'b0;
				state_w = S_IDLE;
			end
		endcase

		// stop wins over everything while playing
		if (i_stop && state_r != S_IDLE) begin
			req_w    = 1'b0;
			finish_w = 1'b1;
			state_w  = S_IDLE;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst_n) begin
		if (i_rst_n) begin
			state_r  <= S_IDLE;
			mode_r   <= MODE_FAST;
			speed_r  <= SPEED_W'(1);
			len_r    <= '0;
			pos_r    <= '0;
			sub_r    <= '0;
			final_r  <= 1'b0;
			phase_r  <= 1'b0;
			req_r    <= 1'b0;
			finish_r <= 1'b0;
			start_r  <= 1'b0;
		end else begin
			state_r  <= state_w;
			mode_r   <= mode_w;
			speed_r  <= speed_w;
			len_r    <= len_w;
			pos_r    <= pos_w;
			sub_r    <= sub_w;
			final_r  <= final_w;
			phase_r  <= phase_w;
			req_r    <= req_w;
			finish_r <= finish_w;
			start_r  <= i_start;
		end
	end

	always_ff @(posedge i_clk) begin
		a_r    <= a_w;
		b_r    <= b_w;
		data_r <= data_w;
	end

endmodule

// File: design/aud_pkg.sv
package aud_pkg;

	// sample and memory geometry
	localparam int SAMPLE_W  = 16;
	localparam int ADDR_W    = 10;
	localparam int RAM_DEPTH = 1024;

	// speed factor, legal 1 to 8, zero is taken as 1
	localparam int SPEED_W = 4;

	// bit clocks per half frame of the left/right clock
	localparam int LRCK_HALF = 20;
	// counter width for one half frame
	localparam int CNT_W = $clog2(LRCK_HALF);

	// playback modes
	typedef enum logic [1:0] {
		MODE_FAST        = 2'd0,
		// each source sample repeated
		MODE_SLOW_HOLD   = 2'd1,
		// straight line between neighbours
		MODE_SLOW_LINEAR = 2'd2
	} play_mode_t;

	// playback processor states
	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		// address of first (or only) sample on the bus
		S_FETCH_A = 3'd1,
		// first sample back, second address on the bus
		S_FETCH_B = 3'd2,
		// second sample capture, then output value
		S_CALC    = 3'd3,
		// waiting for the serializer
		S_SEND    = 3'd4
	} dsp_state_t;

endpackage

// File: design/aud_player.sv
module aud_player (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_play_req,
	input  logic [aud_pkg::SAMPLE_W-1:0] i_play_data,
	output logic                         o_sent_done,
	output logic                         o_daclrck,
	output logic                         o_dacdat
);

	import aud_pkg::*;

	logic [CNT_W-1:0]    cnt_r;
	logic                lrck_r;
	logic [SAMPLE_W-1:0] shift_r;
	logic                busy_r;
	logic                done_r;
	logic                dat_r;

	logic                half_end;
	logic                frame_start;
	logic                in_data_slot;

	assign half_end    = (cnt_r == CNT_W'(LRCK_HALF - 1));
	// lrck about to fall, left half begins on the next clock
	assign frame_start = half_end && lrck_r;
	// bit slots of the left half, one clock behind the lrck edge
	assign in_data_slot = !lrck_r && (cnt_r < CNT_W'(SAMPLE_W));

	assign o_daclrck   = lrck_r;
	assign o_dacdat    = dat_r;
	assign o_sent_done = done_r;

	// half-frame counter and left/right clock
	always_ff @(posedge i_clk or posedge i_rst_n) begin
		if (i_rst_n) begin
			cnt_r  <= '0;
			lrck_r <= 1'b0;
		end else if (half_end) begin
			cnt_r  <= '0;
			lrck_r <= ~lrck_r;
		end else begin
			cnt_r <= cnt_r + CNT_W'(1);
		end
	end

	// sample shifter
	always_ff @(posedge i_clk or posedge i_rst_n) begin
		if (i_rst_n) begin
			shift_r <= '0;
			dat_r   <= 1'b0;
		end else begin
			if (frame_start) begin
				// no request means a silent frame
				shift_r <= i_play_req ? i_play_data : '0;
			end else if (in_data_slot) begin
				shift_r <= shift_r << 1;
			end
			dat_r <= in_data_slot ? shift_r[SAMPLE_W-1] : 1'b0;
		end
	end

	// busy only while the latched request is still standing
	always_ff @(posedge i_clk or posedge i_rst_n) begin
		if (i_rst_n) begin
			busy_r <= 1'b0;
			done_r <= 1'b0;
		end else begin
			if (frame_start) begin
				busy_r <= i_play_req;
			end else if (!i_play_req || done_r) begin
				// request withdrawn mid-frame, e.g. after a stop
				busy_r <= 1'b0;
			end
			// last bit has been on the line for one clock
			done_r <= busy_r && i_play_req && !lrck_r
			          && (cnt_r == CNT_W'(SAMPLE_W));
		end
	end

endmodule

// File: design/aud_top.sv
module aud_top (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	// recording load port
	input  logic                         i_wr_en,
	input  logic [aud_pkg::ADDR_W-1:0]   i_wr_addr,
	input  logic [aud_pkg::SAMPLE_W-1:0] i_wr_data,
	// playback control
	input  logic                         i_start,
	input  logic                         i_stop,
	input  logic                         i_pause,
	input  aud_pkg::play_mode_t          i_mode,
	input  logic [aud_pkg::SPEED_W-1:0]  i_speed,
	input  logic [aud_pkg::ADDR_W:0]     i_record_len,
	// codec side
	output logic                         o_daclrck,
	output logic                         o_dacdat,
	output logic                         o_finish
);

	import aud_pkg::*;

	logic [ADDR_W-1:0]   rd_addr;
	logic [SAMPLE_W-1:0] rd_data;
	logic                play_req;
	logic [SAMPLE_W-1:0] play_data;
	logic                sent_done;

	sample_ram u_ram (
		.i_clk     (i_clk),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	aud_dsp u_dsp (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_start      (i_start),
		.i_stop       (i_stop),
		.i_pause      (i_pause),
		.i_mode       (i_mode),
		.i_speed      (i_speed),
		.i_record_len (i_record_len),
		.o_rd_addr    (rd_addr),
		.i_rd_data    (rd_data),
		.o_play_req   (play_req),
		.o_play_data  (play_data),
		.i_sent_done  (sent_done),
		.o_finish     (o_finish)
	);

	// serializer runs on the same bit clock
	aud_player u_player (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_play_req  (play_req),
		.i_play_data (play_data),
		.o_sent_done (sent_done),
		.o_daclrck   (o_daclrck),
		.o_dacdat    (o_dacdat)
	);

endmodule

// File: design/sample_ram.sv
module sample_ram (
	input  logic                         i_clk,
	input  logic                         i_wr_en,
	input  logic [aud_pkg::ADDR_W-1:0]   i_wr_addr,
	input  logic [aud_pkg::SAMPLE_W-1:0] i_wr_data,
	input  logic [aud_pkg::ADDR_W-1:0]   i_rd_addr,
	output logic [aud_pkg::SAMPLE_W-1:0] o_rd_data
);

	import aud_pkg::*;

	// recorded samples, stand-in for the external sram
	logic [SAMPLE_W-1:0] mem [RAM_DEPTH];
	logic [SAMPLE_W-1:0] rd_data_r;

	assign o_rd_data = rd_data_r;

	// write port, only used while the player is idle
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// registered read, data one clock after the address
	always_ff @(posedge i_clk) begin
		rd_data_r <= mem[i_rd_addr];
	end

endmodule

// File: test/tb_aud_top.sv
module tb_aud_top;

	timeunit 1ns;
	timeprecision 1ps;

	import aud_pkg::*;

	localparam int FRAME_CYCLES = 2 * LRCK_HALF;
	localparam int PAUSE_FRAMES = 3;
	// outputs of all runs, the idle frames of the pause run counted as samples
	localparam int TOTAL_SAMPLES = 10 + 4 + 21 + 15 + 26 + 13 + 19 + 10 + 10;
	localparam int NUM_RUNS = 9;
	localparam int CYCLE_LIMIT = (TOTAL_SAMPLES + 4 * NUM_RUNS) * FRAME_CYCLES + 200;

	logic                i_clk;
	logic                i_rst_n;
	logic                i_wr_en;
	logic [ADDR_W-1:0]   i_wr_addr;
	logic [SAMPLE_W-1:0] i_wr_data;
	logic                i_start;
	logic                i_stop;
	logic                i_pause;
	play_mode_t          i_mode;
	logic [SPEED_W-1:0]  i_speed;
	logic [ADDR_W:0]     i_record_len;
	logic                o_daclrck;
	logic                o_dacdat;
	logic                o_finish;

	// copy of the recording and the sample lists of one run
	logic [SAMPLE_W-1:0] rec [RAM_DEPTH];
	logic [SAMPLE_W-1:0] exp_q [$];
	logic [SAMPLE_W-1:0] got_q [$];
	bit                  gotp_q [$];
	logic [15:0]         lfsr_r;
	bit                  collecting;
	bit                  allow_short;
	bit                  expect_idle;
	string               test_name;
	int                  err_count;
	int                  check_count;
	int                  run_count;
	int                  checks_done;
	int                  cycles;
	event                check_ev;

	aud_top DUT (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_wr_en      (i_wr_en),
		.i_wr_addr    (i_wr_addr),
		.i_wr_data    (i_wr_data),
		.i_start      (i_start),
		.i_stop       (i_stop),
		.i_pause      (i_pause),
		.i_mode       (i_mode),
		.i_speed      (i_speed),
		.i_record_len (i_record_len),
		.o_daclrck    (o_daclrck),
		.o_dacdat     (o_dacdat),
		.o_finish     (o_finish)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles in %s, the run never completed", cycles, test_name);
			$display("checks: %0d, errors: %0d", check_count, err_count + 1);
			$display("Test failed");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// expected output samples of one run
	function automatic void build_expected(input play_mode_t mode, input int speed, input int n);
		int s;
		int k;
		int j;
		int a;
		int b;
		int step;
		exp_q.delete();
		s = (speed == 0) ? 1 : speed;
		if (mode == MODE_FAST) begin
			for (k = 0; k * s < n; k++) begin
				exp_q.push_back(rec[k * s]);
			end
		end else begin
			for (k = 0; k < n - 1; k++) begin
				a = $signed(rec[k]);
				b = $signed(rec[k + 1]);
				// int division truncates toward zero
				step = (b - a) / s;
				for (j = 0; j < s; j++) begin
					if (mode == MODE_SLOW_HOLD) begin
						exp_q.push_back(rec[k]);
					end else begin
						exp_q.push_back(SAMPLE_W'(a + j * step));
					end
				end
			end
			exp_q.push_back(rec[n - 1]);
		end
	endfunction

	task automatic load_recording(input int n);
		int i;
		int j;
		logic [SAMPLE_W-1:0] val;
		for (i = 0; i < n; i++) begin
			for (j = 0; j < SAMPLE_W; j++) begin
				lfsr_r = lfsr_next(lfsr_r);
				val = {val[SAMPLE_W-2:0], lfsr_r[0]};
			end
			rec[i] = val;
			i_wr_en = 1'b1;
			i_wr_addr = ADDR_W'(i);
			i_wr_data = val;
			@(posedge i_clk);
			#2;
		end
		i_wr_en = 1'b0;
	endtask

	task automatic wait_finish(input int max_cycles, output bit seen);
		int i;
		seen = 1'b0;
		for (i = 0; i < max_cycles && !seen; i++) begin
			@(negedge i_clk);
			if (o_finish) begin
				seen = 1'b1;
			end
		end
	endtask

	// pause_at and stop_at count frames after start, -1 leaves them out
	task automatic play_run(input string name, input play_mode_t mode, input int speed,
	                        input int n, input int pause_at, input int stop_at);
		bit seen;
		int extra;
		test_name = name;
		build_expected(mode, speed, n);
		got_q.delete();
		gotp_q.delete();
		allow_short = (stop_at >= 0);
		expect_idle = (pause_at >= 0);
		extra = (pause_at >= 0) ? PAUSE_FRAMES : 0;
		i_mode = mode;
		i_speed = SPEED_W'(speed);
		i_record_len = (ADDR_W+1)'(n);
		// start right after a frame begins, so the next frame carries the first sample
		@(negedge o_daclrck);
		@(posedge i_clk);
		#2;
		collecting = 1'b1;
		i_start = 1'b1;
		@(posedge i_clk);
		#2;
		i_start = 1'b0;
		if (pause_at >= 0) begin
			repeat (pause_at) @(negedge o_daclrck);
			@(posedge i_clk);
			#2;
			i_pause = 1'b1;
			repeat (PAUSE_FRAMES) @(negedge o_daclrck);
			@(posedge i_clk);
			#2;
			i_pause = 1'b0;
		end
		if (stop_at >= 0) begin
			repeat (stop_at) @(negedge o_daclrck);
			@(posedge i_clk);
			#2;
			i_stop = 1'b1;
			@(posedge i_clk);
			#2;
			i_stop = 1'b0;
		end
		wait_finish((exp_q.size() + extra + 4) * FRAME_CYCLES, seen);
		check_count++;
		assert (seen) else begin
			err_count++;
			$display("%s: o_finish never pulsed", name);
		end
		collecting = 1'b0;
		// the last frame is fully captured once the next one begins
		@(negedge o_daclrck);
		@(posedge i_clk);
		#2;
		run_count++;
		-> check_ev;
		wait (checks_done == run_count);
	endtask

	task automatic check_silence(input string name);
		int i;
		got_q.delete();
		gotp_q.delete();
		collecting = 1'b1;
		repeat (2) @(negedge o_daclrck);
		@(posedge i_clk);
		#2;
		collecting = 1'b0;
		@(negedge o_daclrck);
		@(posedge i_clk);
		#2;
		for (i = 0; i < got_q.size(); i++) begin
			check_count++;
			assert (got_q[i] === '0) else begin
				err_count++;
				$display("ERR %s frame %0d: expected %h, actual %h", name, i, 16'h0000, got_q[i]);
			end
		end
	endtask

	// left half capture, bit k sampled mid-cycle k+1 after the lrck fall
	initial begin
		logic [SAMPLE_W-1:0] word;
		bit                  paused;
		int                  b;
		@(negedge i_rst_n);
		forever begin
			@(negedge o_daclrck);
			if (collecting) begin
				paused = i_pause;
				for (b = 0; b < SAMPLE_W; b++) begin
					@(posedge i_clk);
					@(negedge i_clk);
					word = {word[SAMPLE_W-2:0], o_dacdat};
				end
				got_q.push_back(word);
				gotp_q.push_back(paused);
			end
		end
	end

	// lrck half period and the silent right half
	initial begin
		logic lrck_now;
		int   half_len;
		@(negedge i_rst_n);
		@(o_daclrck);
		@(negedge i_clk);
		forever begin
			lrck_now = o_daclrck;
			half_len = 0;
			while (o_daclrck === lrck_now) begin
				half_len++;
				if (lrck_now) begin
					assert (o_dacdat === 1'b0) else begin
						err_count++;
						$display("ERR %s right half: expected 0, actual %b", test_name, o_dacdat);
					end
				end
				@(negedge i_clk);
			end
			check_count++;
			assert (half_len == LRCK_HALF) else begin
				err_count++;
				$display("ERR %s lrck half period: expected %0d, actual %0d",
				         test_name, LRCK_HALF, half_len);
			end
		end
	end

	// compare captured frames of one run with the expected list
	initial begin
		logic [SAMPLE_W-1:0] data_q [$];
		int                  i;
		int                  n_cmp;
		forever begin
			@(check_ev);
			data_q.delete();
			for (i = 0; i < got_q.size(); i++) begin
				// silent frame is fine only while paused
				if (!(gotp_q[i] && got_q[i] === '0)) begin
					data_q.push_back(got_q[i]);
				end
			end
			if (expect_idle) begin
				check_count++;
				assert (got_q.size() > data_q.size()) else begin
					err_count++;
					$display("%s: pause held back no sample", test_name);
				end
			end
			check_count++;
			if (allow_short) begin
				assert (data_q.size() >= 1 && data_q.size() < exp_q.size()) else begin
					err_count++;
					$display("%s: %0d samples played before the stop, expected fewer than %0d",
					         test_name, data_q.size(), exp_q.size());
				end
			end else begin
				assert (data_q.size() == exp_q.size()) else begin
					err_count++;
					$display("%s: played %0d samples, expected %0d",
					         test_name, data_q.size(), exp_q.size());
				end
			end
			n_cmp = (data_q.size() < exp_q.size()) ? data_q.size() : exp_q.size();
			for (i = 0; i < n_cmp; i++) begin
				check_count++;
				assert (data_q[i] === exp_q[i]) else begin
					err_count++;
					$display("ERR %s sample %0d: expected %h, actual %h",
					         test_name, i, exp_q[i], data_q[i]);
				end
			end
			checks_done++;
		end
	end

	initial begin
		i_rst_n = 1'b1;
		i_wr_en = 1'b0;
		i_wr_addr = '0;
		i_wr_data = '0;
		i_start = 1'b0;
		i_stop = 1'b0;
		i_pause = 1'b0;
		i_mode = MODE_FAST;
		i_speed = '0;
		i_record_len = '0;
		lfsr_r = 16'd20;
		collecting = 1'b0;
		allow_short = 1'b0;
		expect_idle = 1'b0;
		test_name = "reset";
		err_count = 0;
		check_count = 0;
		run_count = 0;
		checks_done = 0;
		cycles = 0;
		repeat (4) @(posedge i_clk);
		#2;
		check_count++;
		assert (o_daclrck === 1'b0 && o_dacdat === 1'b0 && o_finish === 1'b0) else begin
			err_count++;
			$display("outputs are not all low while reset is applied");
		end
		i_rst_n = 1'b0;
		@(posedge i_clk);
		#2;

		load_recording(10);
		play_run("fast_s1", MODE_FAST, 1, 10, -1, -1);
		play_run("fast_s3", MODE_FAST, 3, 10, -1, -1);
		load_recording(6);
		play_run("hold_s4", MODE_SLOW_HOLD, 4, 6, -1, -1);
		load_recording(8);
		play_run("linear_s2", MODE_SLOW_LINEAR, 2, 8, -1, -1);
		load_recording(6);
		play_run("linear_s5", MODE_SLOW_LINEAR, 5, 6, -1, -1);
		load_recording(10);
		play_run("pause", MODE_FAST, 1, 10, 3, -1);
		load_recording(10);
		play_run("stop", MODE_SLOW_HOLD, 2, 10, -1, 3);
		check_silence("stop_silence");
		// same recording again, must start over from address 0
		play_run("restart", MODE_FAST, 1, 10, -1, -1);
		play_run("speed0", MODE_FAST, 0, 10, -1, -1);

		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
